/* verilog/cache_pkg.sv */
package cache_pkg;

    // geometry
    localparam int WAYS           = 2;
    localparam int SETS           = 16;
    localparam int WORDS_PER_LINE = 8;

    localparam int INDEX_BITS  = 4;
    localparam int OFFSET_BITS = 3;
    localparam int ALIGN_BITS  = 2;
    localparam int TAG_BITS    = 23;

    typedef logic [0:0]             way_t;
    typedef logic [INDEX_BITS-1:0]  index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [31:0]            word_t;

    // way, index, offset
    typedef logic [$bits(way_t)+INDEX_BITS+OFFSET_BITS-1:0] data_addr_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } addr_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    typedef enum logic [1:0] {
        I_NONE,
        I_INDEX_INVALID,
        I_HIT_INVALID,
        I_INDEX_STORE_TAG
    } cache_inst_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH_1,
        FETCH_2
    } fsm_state_t;

endpackage

/* verilog/bus_pkg.sv */
package bus_pkg;

    import cache_pkg::*;

    // fetch side, both ports share this shape
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    // data[0] is port 1, data[1] is port 2
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        word_t [1:0] data;
    } ibus_resp_t;

    // line refill, always a WORDS_PER_LINE read burst
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

    // tag_lo as seen by index store tag
    typedef struct packed {
        logic valid;
        tag_t tag;
    } taglo_t;

endpackage

/* verilog/meta_ram.sv */
`timescale 1ns/1ps

module meta_ram
    import cache_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,
    input  index_t           rd_index_1,
    input  index_t           rd_index_2,
    input  logic             wr_en,
    input  way_t             wr_way,
    input  index_t           wr_index,
    input  meta_t            wr_meta,
    output meta_t [WAYS-1:0] rd_meta_1,
    output meta_t [WAYS-1:0] rd_meta_2
);

    tag_t tags [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0] valid;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_way][wr_index] <= wr_meta.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_way][wr_index] <= wr_meta.valid;
        end
    end

    // combinational reads, hits resolve in the request cycle
    for (genvar w = 0; w < WAYS; w++) begin : g_read
        assign rd_meta_1[w].valid = valid[w][rd_index_1];
        assign rd_meta_1[w].tag   = tags[w][rd_index_1];
        assign rd_meta_2[w].valid = valid[w][rd_index_2];
        assign rd_meta_2[w].tag   = tags[w][rd_index_2];
    end

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps

module data_ram
    import cache_pkg::*;
(
    input  logic       clk,
    input  data_addr_t addr_1,
    input  data_addr_t addr_2,
    input  logic       wen_2,
    input  word_t      wdata_2,
    output word_t      rdata_1,
    output word_t      rdata_2
);

    word_t mem [WAYS*SETS*WORDS_PER_LINE];

    // port 1 read only
    always_ff @(posedge clk) begin
        rdata_1 <= mem[addr_1];
    end

    // port 2 shared between fetch reads and refill writes
    always_ff @(posedge clk) begin
        if (wen_2) begin
            mem[addr_2] <= wdata_2;
        end
        rdata_2 <= mem[addr_2];
    end

endmodule

/* verilog/plru_table.sv */
`timescale 1ns/1ps

module plru_table
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  index_t index_1,
    input  index_t index_2,
    input  logic   hit_1,
    input  logic   hit_2,
    input  way_t   hit_way_1,
    input  way_t   hit_way_2,
    input  logic   update,
    output way_t   victim_1,
    output way_t   victim_2
);

    // one bit per set, points at the lru way
    logic [SETS-1:0] lru;

    assign victim_1 = lru[index_1];

    // same set: keep port 1's line, take the other way
    assign victim_2 = (index_1 == index_2) ? ~hit_way_1 : lru[index_2];

    always_ff @(posedge clk) begin
        if (resetn) begin
            lru <= '0;
        end else if (update) begin
            if (hit_1) begin
                lru[index_1] <= ~hit_way_1;
            end
            // port 2 last so it wins on a shared set
            if (hit_2) begin
                lru[index_2] <= ~hit_way_2;
            end
        end
    end

endmodule

/* verilog/icache_ctrl.sv */
`timescale 1ns/1ps

module icache_ctrl
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic             clk,
    input  logic             resetn,

    input  ibus_req_t        ireq_1,
    input  ibus_req_t        ireq_2,
    output ibus_resp_t       iresp,
    output cbus_req_t        icreq,
    input  cbus_resp_t       icresp,
    input  cache_inst_t      cache_inst,
    input  taglo_t           tag_lo,

    output index_t           meta_rd_index_1,
    output index_t           meta_rd_index_2,
    input  meta_t [WAYS-1:0] rd_meta_1,
    input  meta_t [WAYS-1:0] rd_meta_2,
    output logic             meta_wr_en,
    output way_t             meta_wr_way,
    output index_t           meta_wr_index,
    output meta_t            meta_wr_meta,

    output data_addr_t       data_addr_1,
    output data_addr_t       data_addr_2,
    output logic             wen_2,
    output word_t            wdata_2,
    input  word_t            rdata_1,
    input  word_t            rdata_2,

    output index_t           plru_index_1,
    output index_t           plru_index_2,
    output logic             plru_hit_1,
    output logic             plru_hit_2,
    output way_t             plru_hit_way_1,
    output way_t             plru_hit_way_2,
    output logic             plru_update,
    input  way_t             victim_1,
    input  way_t             victim_2
);

    addr_t addr_1;
    addr_t addr_2;
    addr_t fill_addr;

    fsm_state_t state;
    way_t       fill_way;
    offset_t    beat;
    logic       fetching;
    logic       last_beat;

    logic [WAYS-1:0] hit_bits_1;
    logic [WAYS-1:0] hit_bits_2;
    logic            hit_1;
    logic            hit_2;
    way_t            hit_way_1;
    way_t            hit_way_2;
    way_t            index_way;

    logic is_fetch;
    logic req_hit;
    logic miss_1;
    logic miss_2;
    logic addr_ok;
    logic fetch_ok;
    logic data_ok_q;

    function automatic way_t way_of(input logic [WAYS-1:0] bits);
        way_t way;
        way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (bits[w]) begin
                way = way_t'(w);
            end
        end
        return way;
    endfunction

    assign addr_1    = ireq_1.addr;
    assign addr_2    = ireq_2.addr;
    assign fetching  = (state == FETCH_1) || (state == FETCH_2);
    assign last_beat = fetching && icresp.ready && icresp.last;
    assign fill_addr = (state == FETCH_2) ? addr_2 : addr_1;

    // port 1's meta read is borrowed by port 2 while it refills
    assign meta_rd_index_1 = (state == FETCH_2) ? addr_2.index : addr_1.index;
    assign meta_rd_index_2 = addr_2.index;

    for (genvar w = 0; w < WAYS; w++) begin : g_hit
        assign hit_bits_1[w] = rd_meta_1[w].valid && (rd_meta_1[w].tag == addr_1.tag);
        assign hit_bits_2[w] = rd_meta_2[w].valid && (rd_meta_2[w].tag == addr_2.tag);
    end

    assign hit_1     = |hit_bits_1;
    assign hit_2     = |hit_bits_2;
    assign hit_way_1 = way_of(hit_bits_1);
    assign hit_way_2 = way_of(hit_bits_2);

    // address bit 6 picks the way for index ops
    assign index_way = addr_1.index[1];

    assign is_fetch = (cache_inst == I_NONE);
    assign req_hit  = ireq_1.valid && hit_1 && (!ireq_2.valid || hit_2);
    assign miss_1   = (state == IDLE) && is_fetch && ireq_1.valid && !hit_1;
    assign miss_2   = (state == IDLE) && is_fetch && ireq_1.valid && hit_1
                      && ireq_2.valid && !hit_2;

    assign fetch_ok = (state == IDLE) && is_fetch && req_hit;
    assign addr_ok  = fetch_ok || ((state == IDLE) && !is_fetch);

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= IDLE;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= fetch_ok;
            case (state)
                IDLE: begin
                    if (miss_1) begin
                        state <= FETCH_1;
                    end else if (miss_2) begin
                        state <= FETCH_2;
                    end
                end
                FETCH_1, FETCH_2: begin
                    if (icresp.ready && icresp.last) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // refill way and beat offset set up in idle
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            beat     <= '0;
            fill_way <= miss_1 ? victim_1 : victim_2;
        end else if (icresp.ready) begin
            beat <= beat + offset_t'(1);
        end
    end

    // refill tag on the last beat and cache ops in idle
    always_comb begin
        meta_wr_en         = last_beat;
        meta_wr_way        = fill_way;
        meta_wr_index      = fill_addr.index;
        meta_wr_meta.valid = 1'b1;
        meta_wr_meta.tag   = fill_addr.tag;
        if (state == IDLE) begin
            case (cache_inst)
                I_INDEX_INVALID: begin
                    meta_wr_en         = 1'b1;
                    meta_wr_way        = index_way;
                    meta_wr_meta.valid = 1'b0;
                    meta_wr_meta.tag   = rd_meta_1[index_way].tag;
                end
                I_HIT_INVALID: begin
                    meta_wr_en         = hit_1;
                    meta_wr_way        = hit_way_1;
                    meta_wr_meta.valid = 1'b0;
                    meta_wr_meta.tag   = rd_meta_1[hit_way_1].tag;
                end
                I_INDEX_STORE_TAG: begin
                    meta_wr_en         = 1'b1;
                    meta_wr_way        = index_way;
                    meta_wr_meta.valid = tag_lo.valid;
                    meta_wr_meta.tag   = tag_lo.tag;
                end
                default: begin
                end
            endcase
        end
    end

    assign data_addr_1 = {hit_way_1, addr_1.index, addr_1.offset};
    assign data_addr_2 = fetching ? {fill_way, fill_addr.index, beat}
                                  : {hit_way_2, addr_2.index, addr_2.offset};
    assign wen_2       = fetching && icresp.ready;
    assign wdata_2     = icresp.data;

    assign plru_index_1   = addr_1.index;
    assign plru_index_2   = addr_2.index;
    assign plru_hit_1     = ireq_1.valid && hit_1;
    assign plru_hit_2     = ireq_2.valid && hit_2;
    assign plru_hit_way_1 = hit_way_1;
    assign plru_hit_way_2 = hit_way_2;
    assign plru_update    = fetch_ok;

    assign iresp.addr_ok = addr_ok;
    assign iresp.data_ok = data_ok_q;
    assign iresp.data[0] = rdata_1;
    assign iresp.data[1] = rdata_2;

    // burst starts at word 0 of the line
    always_comb begin
        icreq.valid       = fetching;
        icreq.addr        = fill_addr;
        icreq.addr.offset = '0;
        icreq.addr.align  = '0;
    end

endmodule

/* verilog/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,
    input  ibus_req_t   ireq_1,
    input  ibus_req_t   ireq_2,
    output ibus_resp_t  iresp,
    output cbus_req_t   icreq,
    input  cbus_resp_t  icresp,
    input  cache_inst_t cache_inst,
    input  taglo_t      tag_lo
);

    index_t           meta_rd_index_1;
    index_t           meta_rd_index_2;
    meta_t [WAYS-1:0] rd_meta_1;
    meta_t [WAYS-1:0] rd_meta_2;
    logic             meta_wr_en;
    way_t             meta_wr_way;
    index_t           meta_wr_index;
    meta_t            meta_wr_meta;

    data_addr_t data_addr_1;
    data_addr_t data_addr_2;
    logic       wen_2;
    word_t      wdata_2;
    word_t      rdata_1;
    word_t      rdata_2;

    index_t plru_index_1;
    index_t plru_index_2;
    logic   plru_hit_1;
    logic   plru_hit_2;
    way_t   plru_hit_way_1;
    way_t   plru_hit_way_2;
    logic   plru_update;
    way_t   victim_1;
    way_t   victim_2;

    icache_ctrl ctrl_inst (
        .clk             (clk),
        .resetn          (resetn),
        .ireq_1          (ireq_1),
        .ireq_2          (ireq_2),
        .iresp           (iresp),
        .icreq           (icreq),
        .icresp          (icresp),
        .cache_inst      (cache_inst),
        .tag_lo          (tag_lo),
        .meta_rd_index_1 (meta_rd_index_1),
        .meta_rd_index_2 (meta_rd_index_2),
        .rd_meta_1       (rd_meta_1),
        .rd_meta_2       (rd_meta_2),
        .meta_wr_en      (meta_wr_en),
        .meta_wr_way     (meta_wr_way),
        .meta_wr_index   (meta_wr_index),
        .meta_wr_meta    (meta_wr_meta),
        .data_addr_1     (data_addr_1),
        .data_addr_2     (data_addr_2),
        .wen_2           (wen_2),
        .wdata_2         (wdata_2),
        .rdata_1         (rdata_1),
        .rdata_2         (rdata_2),
        .plru_index_1    (plru_index_1),
        .plru_index_2    (plru_index_2),
        .plru_hit_1      (plru_hit_1),
        .plru_hit_2      (plru_hit_2),
        .plru_hit_way_1  (plru_hit_way_1),
        .plru_hit_way_2  (plru_hit_way_2),
        .plru_update     (plru_update),
        .victim_1        (victim_1),
        .victim_2        (victim_2)
    );

    meta_ram meta_ram_inst (
        .clk        (clk),
        .resetn     (resetn),
        .rd_index_1 (meta_rd_index_1),
        .rd_index_2 (meta_rd_index_2),
        .wr_en      (meta_wr_en),
        .wr_way     (meta_wr_way),
        .wr_index   (meta_wr_index),
        .wr_meta    (meta_wr_meta),
        .rd_meta_1  (rd_meta_1),
        .rd_meta_2  (rd_meta_2)
    );

    data_ram data_ram_inst (
        .clk     (clk),
        .addr_1  (data_addr_1),
        .addr_2  (data_addr_2),
        .wen_2   (wen_2),
        .wdata_2 (wdata_2),
        .rdata_1 (rdata_1),
        .rdata_2 (rdata_2)
    );

    plru_table plru_table_inst (
        .clk       (clk),
        .resetn    (resetn),
        .index_1   (plru_index_1),
        .index_2   (plru_index_2),
        .hit_1     (plru_hit_1),
        .hit_2     (plru_hit_2),
        .hit_way_1 (plru_hit_way_1),
        .hit_way_2 (plru_hit_way_2),
        .update    (plru_update),
        .victim_1  (victim_1),
        .victim_2  (victim_2)
    );

endmodule

/* tests/cbus_mem_model.sv */
`timescale 1ns/1ps

module cbus_mem_model
    import cache_pkg::*;
    import bus_pkg::*;
#(
    parameter logic [31:0] SEED      = 32'h1,
    parameter int          LOG_DEPTH = 64
) (
    input  logic       clk,
    input  logic       resetn,
    input  cbus_req_t  icreq,
    output cbus_resp_t icresp,
    output int         burst_count,
    output int         beat_count,
    output int         protocol_errors,
    output addr_t      burst_log [LOG_DEPTH]
);

    // word returned for a byte address
    function automatic word_t word_at(input addr_t addr);
        logic [31:0] mixed;
        mixed = addr ^ 32'h5a5a_0000;
        return {mixed[30:0], ^addr};
    endfunction

    initial begin
        addr_t beat_addr;
        int    beat;
        logic  busy;
        void'($urandom(SEED));
        icresp          = '0;
        burst_count     = 0;
        beat_count      = 0;
        protocol_errors = 0;
        beat_addr       = '0;
        beat            = 0;
        busy            = 1'b0;
        forever begin
            @(negedge clk);
            // a beat offered last cycle was taken on the rising edge
            if (icresp.ready) begin
                beat_count++;
                beat++;
                if (icresp.last) begin
                    busy = 1'b0;
                    beat = 0;
                end
            end
            icresp = '0;
            if (resetn) begin
                busy = 1'b0;
                beat = 0;
            end else if (icreq.valid) begin
                if (!busy) begin
                    busy      = 1'b1;
                    beat_addr = icreq.addr;
                    if (burst_count < LOG_DEPTH) begin
                        burst_log[burst_count] = icreq.addr;
                    end
                    burst_count++;
                end
                // roughly one idle cycle in four
                if (($urandom % 4) != 0) begin
                    beat_addr.offset = offset_t'(beat);
                    icresp.ready     = 1'b1;
                    icresp.last      = (beat == WORDS_PER_LINE - 1);
                    icresp.data      = word_at(beat_addr);
                end
            end else if (busy) begin
                // request dropped before the last beat
                protocol_errors++;
                busy = 1'b0;
                beat = 0;
            end
        end
    end

endmodule

/* tests/tb_icache.sv */
`timescale 1ns/1ps

module tb_icache
    import cache_pkg::*;
    import bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SAMPLE_DELAY   = 5;
    localparam int LOG_DEPTH      = 64;

    typedef struct packed {
        logic [3:0]  test;
        cache_inst_t inst;
        logic        valid_1;
        addr_t       addr_1;
        logic        valid_2;
        addr_t       addr_2;
        taglo_t      tag_lo;
        logic        miss_1;
        logic        miss_2;
        logic        check_data;
    } step_t;

    logic        clk;
    logic        resetn;
    ibus_req_t   ireq_1;
    ibus_req_t   ireq_2;
    ibus_resp_t  iresp;
    cbus_req_t   icreq;
    cbus_resp_t  icresp;
    cache_inst_t cache_inst;
    taglo_t      tag_lo;

    int    burst_count;
    int    beat_count;
    int    protocol_errors;
    addr_t burst_log [LOG_DEPTH];

    step_t steps [$];
    string test_names [1:6] = '{"reset state", "hits", "dual miss", "replacement",
                                "cache instructions", "back-pressure"};
    int    checks;
    int    errors;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    logic  timed_out;

    icache_top icache_top_inst (
        .clk        (clk),
        .resetn     (resetn),
        .ireq_1     (ireq_1),
        .ireq_2     (ireq_2),
        .iresp      (iresp),
        .icreq      (icreq),
        .icresp     (icresp),
        .cache_inst (cache_inst),
        .tag_lo     (tag_lo)
    );

    cbus_mem_model #(
        .SEED      (32'ha467_57bc),
        .LOG_DEPTH (LOG_DEPTH)
    ) mem_model_inst (
        .clk             (clk),
        .resetn          (resetn),
        .icreq           (icreq),
        .icresp          (icresp),
        .burst_count     (burst_count),
        .beat_count      (beat_count),
        .protocol_errors (protocol_errors),
        .burst_log       (burst_log)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic addr_t make_addr(input tag_t tag, input index_t index,
                                        input offset_t offset);
        addr_t a;
        a.tag    = tag;
        a.index  = index;
        a.offset = offset;
        a.align  = '0;
        return a;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        addr_t line;
        line        = a;
        line.offset = '0;
        return line;
    endfunction

    // memory contents: address ^ 5a5a0000, shifted up, parity in bit 0
    function automatic word_t expected_word(input addr_t a);
        logic [31:0] x;
        x = a ^ 32'h5a5a_0000;
        return {x[30:0], ^a};
    endfunction

    task automatic add_fetch(input int test, input addr_t a1, input logic v2, input addr_t a2,
                             input logic m1, input logic m2, input logic check_data);
        step_t s;
        s = '0;
        s.test       = 4'(test);
        s.inst       = I_NONE;
        s.valid_1    = 1'b1;
        s.addr_1     = a1;
        s.valid_2    = v2;
        s.addr_2     = a2;
        s.miss_1     = m1;
        s.miss_2     = m2;
        s.check_data = check_data;
        steps.push_back(s);
    endtask

    task automatic add_cache_op(input int test, input cache_inst_t inst, input addr_t a1,
                                input logic tl_valid, input tag_t tl_tag);
        step_t s;
        s = '0;
        s.test          = 4'(test);
        s.inst          = inst;
        s.valid_1       = 1'b1;
        s.addr_1        = a1;
        s.tag_lo.valid  = tl_valid;
        s.tag_lo.tag    = tl_tag;
        steps.push_back(s);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        logic ok;
        ok = (got === expected);
        checks++;
        if (!ok) begin
            errors++;
            test_errors++;
        end
        assert (ok) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_test(input int id);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", id, test_names[id],
                 (test_errors == 0) ? "ok" : "failed", test_errors);
        test_errors = 0;
    endtask

    task automatic run_step(input step_t s, input int row);
        int bursts_before;
        int beats_before;
        int exp_bursts;
        int cycles;
        int slot;
        bursts_before = burst_count;
        beats_before  = beat_count;
        exp_bursts    = int'(s.miss_1) + int'(s.miss_2);
        @(negedge clk);
        ireq_1.valid = s.valid_1;
        ireq_1.addr  = s.addr_1;
        ireq_2.valid = s.valid_2;
        ireq_2.addr  = s.addr_2;
        cache_inst   = s.inst;
        tag_lo       = s.tag_lo;
        #SAMPLE_DELAY;
        cycles = 0;
        while (iresp.addr_ok !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            check_value("iresp.data_ok", iresp.data_ok, 0);
            @(negedge clk);
            #SAMPLE_DELAY;
            cycles++;
        end
        if (iresp.addr_ok !== 1'b1) begin
            $display("step %0d: no addr_ok within %0d cycles, giving up", row, TIMEOUT_CYCLES);
            timed_out = 1'b1;
            errors++;
            test_errors++;
            return;
        end
        check_value("iresp.data_ok", iresp.data_ok, 0);
        // taken on the rising edge, response due in this cycle
        @(negedge clk);
        ireq_1.valid = 1'b0;
        ireq_2.valid = 1'b0;
        cache_inst   = I_NONE;
        #SAMPLE_DELAY;
        if (s.inst == I_NONE) begin
            check_value("iresp.data_ok", iresp.data_ok, 1);
            if (s.check_data) begin
                check_value("iresp.data[0]", iresp.data[0], expected_word(s.addr_1));
                if (s.valid_2) begin
                    check_value("iresp.data[1]", iresp.data[1], expected_word(s.addr_2));
                end
            end
        end else begin
            check_value("iresp.data_ok", iresp.data_ok, 0);
        end
        check_value("burst count", burst_count - bursts_before, exp_bursts);
        check_value("beat count", beat_count - beats_before, exp_bursts * WORDS_PER_LINE);
        if (burst_count == bursts_before + exp_bursts && burst_count <= LOG_DEPTH) begin
            slot = bursts_before;
            // port 1 line comes first
            if (s.miss_1) begin
                check_value("icreq.addr", burst_log[slot], line_of(s.addr_1));
                slot++;
            end
            if (s.miss_2) begin
                check_value("icreq.addr", burst_log[slot], line_of(s.addr_2));
            end
        end
    endtask

    task automatic build_table();
        add_fetch(1, make_addr(23'h100, 1, 3), 0, '0, 1, 0, 1);
        add_fetch(2, make_addr(23'h100, 1, 0), 1, make_addr(23'h100, 1, 7), 0, 0, 1);
        add_fetch(2, make_addr(23'h200, 2, 5), 0, '0, 1, 0, 1);
        add_fetch(2, make_addr(23'h200, 2, 1), 1, make_addr(23'h100, 1, 4), 0, 0, 1);
        add_fetch(3, make_addr(23'h300, 3, 2), 1, make_addr(23'h400, 4, 6), 1, 1, 1);
        add_fetch(3, make_addr(23'h500, 5, 0), 1, make_addr(23'h600, 5, 1), 1, 1, 1);
        add_fetch(3, make_addr(23'h400, 4, 0), 1, make_addr(23'h300, 3, 7), 0, 0, 1);
        // A, B, A, C, A, B in set 6
        add_fetch(4, make_addr(23'h1000, 6, 0), 0, '0, 1, 0, 1);
        add_fetch(4, make_addr(23'h2000, 6, 1), 0, '0, 1, 0, 1);
        add_fetch(4, make_addr(23'h1000, 6, 2), 0, '0, 0, 0, 1);
        add_fetch(4, make_addr(23'h3000, 6, 3), 0, '0, 1, 0, 1);
        add_fetch(4, make_addr(23'h1000, 6, 4), 0, '0, 0, 0, 1);
        add_fetch(4, make_addr(23'h2000, 6, 5), 0, '0, 1, 0, 1);
        add_cache_op(5, I_HIT_INVALID, make_addr(23'h100, 1, 0), 0, '0);
        add_fetch(5, make_addr(23'h100, 1, 2), 0, '0, 1, 0, 1);
        // set 4 maps to way 0, where its line sits
        add_cache_op(5, I_INDEX_INVALID, make_addr(23'h7777, 4, 0), 0, '0);
        add_fetch(5, make_addr(23'h400, 4, 3), 0, '0, 1, 0, 1);
        add_cache_op(5, I_INDEX_INVALID, make_addr(23'h0, 5, 0), 0, '0);
        add_fetch(5, make_addr(23'h600, 5, 4), 1, make_addr(23'h500, 5, 6), 0, 1, 1);
        add_cache_op(5, I_INDEX_STORE_TAG, make_addr(23'h0, 7, 0), 1, 23'h7000);
        add_fetch(5, make_addr(23'h7000, 7, 2), 0, '0, 0, 0, 0);
        add_cache_op(5, I_INDEX_STORE_TAG, make_addr(23'h0, 6, 0), 0, 23'h0);
        add_fetch(5, make_addr(23'h2000, 6, 0), 0, '0, 1, 0, 1);
        add_fetch(5, make_addr(23'h1000, 6, 1), 0, '0, 1, 0, 1);
        add_fetch(6, make_addr(23'h11111, 9, 5), 1, make_addr(23'h22222, 10, 3), 1, 1, 1);
        add_fetch(6, make_addr(23'h33333, 9, 0), 1, make_addr(23'h11111, 9, 7), 1, 0, 1);
        add_fetch(6, make_addr(23'h22222, 10, 7), 1, make_addr(23'h33333, 9, 2), 0, 0, 1);
    endtask

    initial begin
        int current;
        ireq_1       = '0;
        ireq_2       = '0;
        cache_inst   = I_NONE;
        tag_lo       = '0;
        resetn       = 1'b1;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        build_table();
        repeat (10) @(negedge clk);
        resetn = 1'b0;
        @(negedge clk);
        #SAMPLE_DELAY;
        check_value("iresp.addr_ok", iresp.addr_ok, 0);
        check_value("iresp.data_ok", iresp.data_ok, 0);
        check_value("icreq.valid", icreq.valid, 0);
        current = 1;
        foreach (steps[i]) begin
            if (timed_out) begin
                break;
            end
            if (int'(steps[i].test) != current) begin
                report_test(current);
                current = int'(steps[i].test);
            end
            run_step(steps[i], i);
        end
        check_value("protocol errors", protocol_errors, 0);
        report_test(current);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
verilog/cache_pkg.sv
verilog/bus_pkg.sv
verilog/meta_ram.sv
verilog/data_ram.sv
verilog/plru_table.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tests/cbus_mem_model.sv
tests/tb_icache.sv
